// ==== testbench/alu_cases.txt ====
# name opcode op1 op2 result flags, all numbers in hex
# flags are Z V N in bits 2 1 0, carried through the file in order from reset
add_basic     0 0003 0004 0007 0
add_pos_ovfl  0 7fff 0001 7fff 2
sub_basic     1 0005 0007 fffe 1
sub_zero      1 1234 1234 0000 4
sub_pos_ovfl  1 7fff ffff 7fff 2
sub_neg_ovfl  1 8000 0001 8000 3
add_neg_ovfl  0 8000 ffff 8000 3
xor_zero      2 a5a5 a5a5 0000 7
xor_basic     2 1234 0ff0 1dc4 3
sll_0         4 8001 0000 8001 3
sll_1         4 8001 0011 0002 3
sll_15        4 0002 000f 0000 7
sra_0         5 8004 0000 8004 3
sra_1         5 8004 0001 c002 3
sra_15_neg    5 8000 000f ffff 3
ror_0         6 1234 0000 1234 3
ror_1         6 0001 0001 8000 3
ror_15        6 8001 000f 0003 3
llb           8 abcd 1234 ab34 3
lhb           9 abcd 1234 34cd 3
sra_15_pos    5 7fff 000f 0000 7
red_basic     3 1234 5678 0114 7
red_max       3 ffff ffff 03fc 7
paddsb_mix    7 7831 1f2e 785f 7
add_neg       0 0001 fffd fffe 1
illegal_a     a 1234 5678 0000 1
illegal_f     f ffff ffff 0000 1
paddsb_neg    7 8888 8888 8888 1
sll_4         4 00ff 0004 0ff0 1

// ==== list.f ====
+incdir+hdl
hdl/alu_pkg.sv
hdl/satAddSub.sv
hdl/reductionAdder.sv
hdl/shifter.sv
hdl/alu.sv
hdl/executeStage.sv
hdl/resultQueue.sv
hdl/aluExecUnit.sv
testbench/aluExecUnit_checker.sv
testbench/tb_aluExecUnit.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_aluExecUnit -o simv

output=$(./obj_dir/simv 2>&1 || true)
echo "$output"

if echo "$output" | grep -q -x -F "Result: PASSED"; then
	exit 0
else
	exit 1
fi

// ==== testbench/tb_aluExecUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_aluExecUnit;
	import alu_pkg::*;
	`include "alu_config.svh"

	localparam int MaxCycles = 2000;
	localparam int CreditWait = 8;

	logic clk;
	logic rstN;
	logic opValid;
	aluOp_t opCode;
	word_t op1;
	word_t op2;
	logic resultPop;
	logic opCredit;
	logic resultValid;
	word_t result;
	flags_t resultFlags;

	// One entry per case line, in file order
	logic [127:0] caseName [$];
	logic [3:0] caseOp [$];
	word_t caseOp1 [$];
	word_t caseOp2 [$];
	word_t caseResult [$];
	flags_t caseFlags [$];

	logic [31:0] lfsr;
	credit_t credits;
	int issued;
	int checked;

	aluExecUnit UUT (
		.clk(clk),
		.rstN(rstN),
		.opValid(opValid),
		.opCode(opCode),
		.op1(op1),
		.op2(op2),
		.resultPop(resultPop),
		.opCredit(opCredit),
		.resultValid(resultValid),
		.result(result),
		.resultFlags(resultFlags)
	);

	always #50 clk = ~clk;

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] stepLfsr(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ 32'h80200003;
		end
		return next;
	endfunction

	task automatic drawBit(output logic bitOut);
		lfsr = stepLfsr(lfsr);
		bitOut = lfsr[0];
	endtask

	task automatic stopOnError();
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic reportError(input string msg);
		$display("ERROR: %s", msg);
		stopOnError();
	endtask

	task automatic checkWord(input logic [127:0] name, input word_t expected,
			input word_t actual);
		if (actual !== expected) begin
			$display("FAIL %0s result expected %h actual %h", name, expected, actual);
			stopOnError();
		end
	endtask

	task automatic checkFlags(input logic [127:0] name, input flags_t expected,
			input flags_t actual);
		if (actual !== expected) begin
			$display("FAIL %0s flags expected %b actual %b", name, expected, actual);
			stopOnError();
		end
	endtask

	task automatic loadCases();
		int fd;
		int got;
		int fields;
		string line;
		logic [127:0] name;
		logic [3:0] op;
		word_t a;
		word_t b;
		word_t res;
		flags_t fl;
		fd = $fopen("testbench/alu_cases.txt", "r");
		if (fd == 0) begin
			reportError("cannot open testbench/alu_cases.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			got = $fgets(line, fd);
			// Comment lines start with a hash
			if (got > 0 && line.len() > 1 && line[0] != "#") begin
				fields = $sscanf(line, "%s %h %h %h %h %h", name, op, a, b, res, fl);
				if (fields != 6) begin
					reportError({"malformed case line: ", line});
				end
				caseName.push_back(name);
				caseOp.push_back(op);
				caseOp1.push_back(a);
				caseOp2.push_back(b);
				caseResult.push_back(res);
				caseFlags.push_back(fl);
			end
		end
		$fclose(fd);
	endtask

	task automatic issueCase(input int idx);
		opValid = 1'b1;
		opCode = aluOp_t'(caseOp[idx]);
		op1 = caseOp1[idx];
		op2 = caseOp2[idx];
		credits = credits - credit_t'(1);
		issued++;
	endtask

	task automatic returnCredit();
		if (credits == credit_t'(`ALU_QUEUE_DEPTH)) begin
			reportError("credit returned while the sender already holds every credit");
		end
		credits = credits + credit_t'(1);
	endtask

	initial begin
		int cycles;
		logic takeBit;
		clk = 1'b0;
		rstN = 1'b0;
		opValid = 1'b0;
		opCode = ADD;
		op1 = '0;
		op2 = '0;
		resultPop = 1'b0;
		lfsr = 32'hf683;
		credits = credit_t'(`ALU_QUEUE_DEPTH);
		issued = 0;
		checked = 0;
		loadCases();
		if (caseName.size() == 0) begin
			reportError("no cases found in the case file");
		end

		repeat (16) @(negedge clk);
		rstN = 1'b1;

		// Latency on an empty queue, using the first case
		@(negedge clk);
		issueCase(0);
		@(negedge clk);
		opValid = 1'b0;
		if (resultValid) begin
			reportError("resultValid rose one cycle after acceptance");
		end
		@(negedge clk);
		if (!resultValid) begin
			reportError("resultValid not high two cycles after acceptance");
		end

		// Random issue against random consumer stalls
		cycles = 0;
		while (checked < caseName.size()) begin
			@(negedge clk);
			cycles++;
			if (cycles > MaxCycles) begin
				reportError("timeout waiting for all results to be popped");
			end
			resultPop = 1'b0;
			opValid = 1'b0;
			if (opCredit) begin
				returnCredit();
			end
			if (resultValid) begin
				drawBit(takeBit);
				if (takeBit) begin
					checkWord(caseName[checked], caseResult[checked], result);
					checkFlags(caseName[checked], caseFlags[checked], resultFlags);
					resultPop = 1'b1;
					checked++;
				end
			end
			if (issued < caseName.size() && credits != '0) begin
				drawBit(takeBit);
				if (takeBit) begin
					issueCase(issued);
				end
			end
		end

		// Last credit comes back the cycle after the last pop
		cycles = 0;
		while (credits != credit_t'(`ALU_QUEUE_DEPTH)) begin
			@(negedge clk);
			cycles++;
			resultPop = 1'b0;
			if (opCredit) begin
				returnCredit();
			end
			if (cycles > CreditWait) begin
				reportError("credit count did not return to the queue depth");
			end
		end
		if (resultValid) begin
			reportError("result queue still holds an entry after the last pop");
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/aluExecUnit_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "alu_config.svh"

module aluExecUnit_checker (
	input logic clk,
	input logic rstN,
	input logic pushValid,
	input logic resultPop,
	input logic resultValid,
	input logic opCredit,
	input logic [`ALU_QPTR_WIDTH-1:0] rdPtr,
	input logic [`ALU_QPTR_WIDTH:0] count
);

	// Credits keep the execute register plus the queue within the depth
	pushWhileFull: assert property (@(posedge clk) disable iff (!rstN)
		!(pushValid && count == (`ALU_QPTR_WIDTH+1)'(`ALU_QUEUE_DEPTH)))
		else $error("push into a full result queue");

	popWhileEmpty: assert property (@(posedge clk) disable iff (!rstN)
		resultPop |-> resultValid)
		else $error("pop from an empty result queue");

	// One credit in the cycle after each entry leaves the head
	creditAfterPop: assert property (@(posedge clk) disable iff (!rstN)
		opCredit == (rdPtr != $past(rdPtr)))
		else $error("opCredit does not follow a pop by one cycle");

	validInReset: assert property (@(posedge clk) !rstN |-> !resultValid)
		else $error("resultValid high during reset");

endmodule

bind resultQueue aluExecUnit_checker queueCheck (
	.clk(clk),
	.rstN(rstN),
	.pushValid(pushValid),
	.resultPop(resultPop),
	.resultValid(resultValid),
	.opCredit(opCredit),
	.rdPtr(rdPtr),
	.count(count)
);

`default_nettype wire

// ==== hdl/aluExecUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluExecUnit (
	input logic clk,
	input logic rstN,
	input logic opValid,
	input alu_pkg::aluOp_t opCode,
	input alu_pkg::word_t op1,
	input alu_pkg::word_t op2,
	input logic resultPop,
	output logic opCredit,
	output logic resultValid,
	output alu_pkg::word_t result,
	output alu_pkg::flags_t resultFlags
);
	import alu_pkg::*;

	aluOp_t aluOpCode;
	word_t aluOp1;
	word_t aluOp2;
	word_t aluResult;
	flags_t rawFlags;
	logic pushValid;
	word_t pushResult;
	flags_t pushFlags;

	executeStage exec (
		.clk(clk),
		.rstN(rstN),
		.opValid(opValid),
		.opCode(opCode),
		.op1(op1),
		.op2(op2),
		.aluResult(aluResult),
		.rawFlags(rawFlags),
		.aluOpCode(aluOpCode),
		.aluOp1(aluOp1),
		.aluOp2(aluOp2),
		.pushValid(pushValid),
		.pushResult(pushResult),
		.pushFlags(pushFlags)
	);

	alu aluCore (
		.opCode(aluOpCode),
		.op1(aluOp1),
		.op2(aluOp2),
		.aluResult(aluResult),
		.rawFlags(rawFlags)
	);

	resultQueue queue (
		.clk(clk),
		.rstN(rstN),
		.pushValid(pushValid),
		.pushResult(pushResult),
		.pushFlags(pushFlags),
		.resultPop(resultPop),
		.resultValid(resultValid),
		.result(result),
		.resultFlags(resultFlags),
		.opCredit(opCredit)
	);

endmodule

`default_nettype wire

// ==== hdl/resultQueue.sv ====
`timescale 1ns/10ps
`default_nettype none

module resultQueue (
	input logic clk,
	input logic rstN,
	input logic pushValid,
	input alu_pkg::word_t pushResult,
	input alu_pkg::flags_t pushFlags,
	input logic resultPop,
	output logic resultValid,
	output alu_pkg::word_t result,
	output alu_pkg::flags_t resultFlags,
	output logic opCredit
);
	import alu_pkg::*;
	`include "alu_config.svh"

	word_t resultMem [`ALU_QUEUE_DEPTH];
	flags_t flagsMem [`ALU_QUEUE_DEPTH];
	logic [`ALU_QPTR_WIDTH-1:0] rdPtr;
	logic [`ALU_QPTR_WIDTH-1:0] wrPtr;
	logic [`ALU_QPTR_WIDTH:0] count;
	logic pop;

	assign resultValid = (count != '0);
	assign pop = resultPop && resultValid;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
			opCredit <= 1'b0;
		end else begin
			if (pushValid) begin
				wrPtr <= wrPtr + `ALU_QPTR_WIDTH'(1);
			end
			if (pop) begin
				rdPtr <= rdPtr + `ALU_QPTR_WIDTH'(1);
			end
			case ({pushValid, pop})
				2'b10: count <= count + (`ALU_QPTR_WIDTH+1)'(1);
				2'b01: count <= count - (`ALU_QPTR_WIDTH+1)'(1);
				default: ;
			endcase
			// One credit back for every entry that leaves
			opCredit <= pop;
		end
	end

	always_ff @(posedge clk) begin
		if (pushValid) begin
			resultMem[wrPtr] <= pushResult;
			flagsMem[wrPtr] <= pushFlags;
		end
	end

	assign result = resultMem[rdPtr];
	assign resultFlags = flagsMem[rdPtr];

endmodule

`default_nettype wire

// ==== hdl/executeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module executeStage (
	input logic clk,
	input logic rstN,
	input logic opValid,
	input alu_pkg::aluOp_t opCode,
	input alu_pkg::word_t op1,
	input alu_pkg::word_t op2,
	input alu_pkg::word_t aluResult,
	input alu_pkg::flags_t rawFlags,
	output alu_pkg::aluOp_t aluOpCode,
	output alu_pkg::word_t aluOp1,
	output alu_pkg::word_t aluOp2,
	output logic pushValid,
	output alu_pkg::word_t pushResult,
	output alu_pkg::flags_t pushFlags
);
	import alu_pkg::*;

	flags_t flagReg;
	flags_t updateMask;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pushValid <= 1'b0;
			flagReg <= '0;
		end else begin
			pushValid <= opValid;
			if (pushValid) begin
				flagReg <= pushFlags;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (opValid) begin
			aluOpCode <= opCode;
			aluOp1 <= op1;
			aluOp2 <= op2;
		end
	end

	// Z/V/N for add and subtract, Z only for XOR and shifts
	always_comb begin
		case (aluOpCode)
			ADD, SUB: updateMask = 3'b111;
			XOR, SLL, SRA, ROR: updateMask = 3'b100;
			default: updateMask = 3'b000;
		endcase
	end

	assign pushFlags = (rawFlags & updateMask) | (flagReg & ~updateMask);
	assign pushResult = aluResult;

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
	input alu_pkg::aluOp_t opCode,
	input alu_pkg::word_t op1,
	input alu_pkg::word_t op2,
	output alu_pkg::word_t aluResult,
	output alu_pkg::flags_t rawFlags
);
	import alu_pkg::*;

	word_t addSubSum;
	word_t redSum;
	word_t shiftOut;
	word_t nibbleSum;
	logic addSubOvfl;
	logic [1:0] shiftMode;

	satAddSub addSub (
		.a(op1),
		.b(op2),
		.subtract(opCode == SUB),
		.sum(addSubSum),
		.ovfl(addSubOvfl)
	);

	reductionAdder redAdd (
		.a(op1),
		.b(op2),
		.sum(redSum)
	);

	// SLL, SRA and ROR map onto modes 0, 1 and 2 through the low opcode bits
	assign shiftMode = opCode[1:0];

	shifter shift (
		.value(op1),
		.shamt(op2[3:0]),
		.mode(shiftMode),
		.shifted(shiftOut)
	);

	// Four independent signed nibble adds, clamped to 7 or -8
	for (genvar i = 0; i < 4; i++) begin : gNibble
		logic [3:0] rawNibble;
		logic nibbleOvfl;

		assign rawNibble = op1[4*i +: 4] + op2[4*i +: 4];
		assign nibbleOvfl = (op1[4*i+3] == op2[4*i+3]) && (rawNibble[3] != op1[4*i+3]);
		assign nibbleSum[4*i +: 4] = nibbleOvfl ? (op1[4*i+3] ? 4'b1000 : 4'b0111) : rawNibble;
	end

	always_comb begin
		case (opCode)
			ADD, SUB: aluResult = addSubSum;
			XOR: aluResult = op1 ^ op2;
			RED: aluResult = redSum;
			SLL, SRA, ROR: aluResult = shiftOut;
			PADDSB: aluResult = nibbleSum;
			LLB: aluResult = {op1[15:8], op2[7:0]};
			LHB: aluResult = {op2[7:0], op1[7:0]};
			default: aluResult = '0;
		endcase
	end

	// V is only meaningful for ADD and SUB, the stage masks it otherwise
	assign rawFlags = {aluResult == 16'h0000, addSubOvfl, aluResult[15]};

endmodule

`default_nettype wire

// ==== hdl/shifter.sv ====
`timescale 1ns/10ps
`default_nettype none

module shifter (
	input alu_pkg::word_t value,
	input alu_pkg::shamt_t shamt,
	input logic [1:0] mode,
	output alu_pkg::word_t shifted
);
	import alu_pkg::*;

	word_t level;

	// Four levels, level i moves by 2**i when shamt[i] is set
	always_comb begin
		level = value;
		for (int i = 0; i < 4; i++) begin
			if (shamt[i]) begin
				case (mode)
					2'd0: level = level << (1 << i);
					2'd1: level = $signed(level) >>> (1 << i);
					2'd2: level = (level >> (1 << i)) | (level << (16 - (1 << i)));
					default: ;
				endcase
			end
		end
	end

	assign shifted = level;

endmodule

`default_nettype wire

// ==== hdl/reductionAdder.sv ====
`timescale 1ns/10ps
`default_nettype none

module reductionAdder (
	input alu_pkg::word_t a,
	input alu_pkg::word_t b,
	output alu_pkg::word_t sum
);

	logic [8:0] lowSum;
	logic [8:0] highSum;
	logic [11:0] total;

	// Byte pairs first, carry kept in bit 8
	assign lowSum = {1'b0, a[7:0]} + {1'b0, b[7:0]};
	assign highSum = {1'b0, a[15:8]} + {1'b0, b[15:8]};

	assign total = {3'b000, lowSum} + {3'b000, highSum};

	// Sign extend from bit 11
	assign sum = {{4{total[11]}}, total};

endmodule

`default_nettype wire

// ==== hdl/satAddSub.sv ====
`timescale 1ns/10ps
`default_nettype none

module satAddSub (
	input alu_pkg::word_t a,
	input alu_pkg::word_t b,
	input logic subtract,
	output alu_pkg::word_t sum,
	output logic ovfl
);
	import alu_pkg::*;

	word_t bEff;
	word_t rawSum;

	// Subtract is a + ~b + 1
	assign bEff = subtract ? ~b : b;
	assign rawSum = a + bEff + {15'b0, subtract};

	// Operands agree in sign but the raw sum does not
	assign ovfl = (a[15] == bEff[15]) && (rawSum[15] != a[15]);

	always_comb begin
		if (ovfl) begin
			sum = a[15] ? 16'h8000 : 16'h7FFF;
		end else begin
			sum = rawSum;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

	// Data word for operands and results
	typedef logic [15:0] word_t;

	// Shift amount taken from op2[3:0]
	typedef logic [3:0] shamt_t;

	// Bit 2 = Z, bit 1 = V, bit 0 = N
	typedef logic [2:0] flags_t;

	// Sender side credit counter, holds 0 up to the queue depth
	typedef logic [2:0] credit_t;

	// Values 10 to 15 are illegal
	typedef enum logic [3:0] {
		ADD    = 4'd0,
		SUB    = 4'd1,
		XOR    = 4'd2,
		RED    = 4'd3,
		SLL    = 4'd4,
		SRA    = 4'd5,
		ROR    = 4'd6,
		PADDSB = 4'd7,
		LLB    = 4'd8,
		LHB    = 4'd9
	} aluOp_t;

endpackage

`default_nettype wire

// ==== hdl/alu_config.svh ====
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// Number of result queue slots, also the sender's initial credit count
`define ALU_QUEUE_DEPTH 4

// Read and write pointer width of the result queue
`define ALU_QPTR_WIDTH 2

`endif
